/* Makefile */
# Verilator build for the execute unit testbench

TOP := tb_exu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* design/exu_defs.svh */
// ------------------------------------------------
// execute unit width and count definitions
// ------------------------------------------------

`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// data word width
`define EXU_XLEN        32

// general register index width
`define EXU_REG_ADDR_W  5

// shift amount bits, taken from the low end of operand 1
`define EXU_SHAMT_W     5

`endif

/* design/exu_execute_stage.sv */
// ------------------------------------------------
// execute unit execute stage
// logic, shift, arithmetic, count, product and
// move results, registered with their hi/lo write
// ------------------------------------------------

`timescale 1ns/1ps

`include "exu_defs.svh"

module exu_execute_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    prep_valid_i,
    input  exu_pkg::exu_prep_t      prep_i,
    input  exu_pkg::word_t          hi_i,       // newest hi, forwarded
    input  exu_pkg::word_t          lo_i,
    output logic                    ex_valid_o,
    output exu_pkg::exu_result_t    ex_res_o,
    output exu_pkg::hilo_wr_t       ex_hilo_o
);

    localparam int CNT_W = $clog2(`EXU_XLEN) + 1;   // counts 0 to xlen

    exu_pkg::word_t         sum;
    logic                   sub_op;
    logic                   ov_sum;
    logic                   lt;
    logic [`EXU_SHAMT_W-1:0] shamt;
    exu_pkg::word_t         logic_res;
    exu_pkg::word_t         shift_res;
    exu_pkg::word_t         arith_res;
    exu_pkg::word_t         move_res;
    exu_pkg::dword_t        prod_mag;
    exu_pkg::dword_t        prod;
    exu_pkg::exu_result_t   res_d;
    exu_pkg::hilo_wr_t      hilo_d;
    exu_pkg::exu_result_t   res_q;
    exu_pkg::hilo_wr_t      hilo_q;
    logic                   valid_q;

    function automatic logic [CNT_W-1:0] lead_zero_cnt(input exu_pkg::word_t v);
        logic [CNT_W-1:0] n;
        n = CNT_W'(`EXU_XLEN);
        for (int i = 0; i < `EXU_XLEN; i++) begin
            if (v[i]) begin
                n = CNT_W'(`EXU_XLEN - 1 - i);  // highest set bit wins
            end
        end
        return n;
    endfunction

    assign sum = prep_i.reg1 + prep_i.reg2_mux;    // reg1 - reg2 when reg2_mux is negated

    assign sub_op = (prep_i.op == exu_pkg::OP_SUB) || (prep_i.op == exu_pkg::OP_SUBU);

    // overflow needs matching effective signs and a flipped result sign
    assign ov_sum = (prep_i.reg1[`EXU_XLEN-1] == (prep_i.reg2[`EXU_XLEN-1] ^ sub_op)) &&
                    (sum[`EXU_XLEN-1] != prep_i.reg1[`EXU_XLEN-1]);

    // signed: neg < pos, otherwise the sign of the difference decides
    assign lt = (prep_i.op == exu_pkg::OP_SLT) ?
                ((prep_i.reg1[`EXU_XLEN-1] && !prep_i.reg2[`EXU_XLEN-1]) ||
                 (!prep_i.reg1[`EXU_XLEN-1] && !prep_i.reg2[`EXU_XLEN-1] &&
                  sum[`EXU_XLEN-1]) ||
                 (prep_i.reg1[`EXU_XLEN-1] && prep_i.reg2[`EXU_XLEN-1] &&
                  sum[`EXU_XLEN-1])) :
                (prep_i.reg1 < prep_i.reg2);

    assign shamt = prep_i.reg1[`EXU_SHAMT_W-1:0];

    assign prod_mag = exu_pkg::dword_t'(prep_i.mul_a) * exu_pkg::dword_t'(prep_i.mul_b);
    assign prod     = prep_i.mul_neg ? -prod_mag : prod_mag;

    always_comb begin
        logic_res = '0;
        shift_res = '0;
        arith_res = '0;
        move_res  = '0;
        case (prep_i.op)
            exu_pkg::OP_OR:    logic_res = prep_i.reg1 | prep_i.reg2;
            exu_pkg::OP_AND:   logic_res = prep_i.reg1 & prep_i.reg2;
            exu_pkg::OP_NOR:   logic_res = ~(prep_i.reg1 | prep_i.reg2);
            exu_pkg::OP_XOR:   logic_res = prep_i.reg1 ^ prep_i.reg2;
            exu_pkg::OP_SLL:   shift_res = prep_i.reg2 << shamt;
            exu_pkg::OP_SRL:   shift_res = prep_i.reg2 >> shamt;
            exu_pkg::OP_SRA:   shift_res = $signed(prep_i.reg2) >>> shamt;  // sign fill
            exu_pkg::OP_ADD, exu_pkg::OP_ADDU,
            exu_pkg::OP_SUB, exu_pkg::OP_SUBU: arith_res = sum;
            exu_pkg::OP_SLT, exu_pkg::OP_SLTU: arith_res = exu_pkg::word_t'(lt);
            exu_pkg::OP_CLZ:   arith_res = exu_pkg::word_t'(lead_zero_cnt(prep_i.reg1));
            exu_pkg::OP_CLO:   arith_res = exu_pkg::word_t'(lead_zero_cnt(~prep_i.reg1));
            exu_pkg::OP_MFHI:  move_res  = hi_i;
            exu_pkg::OP_MFLO:  move_res  = lo_i;
            default: ;
        endcase
    end

    // result class follows the opcode
    always_comb begin
        res_d.wd   = prep_i.wd;
        res_d.wreg = prep_valid_i && prep_i.wreg &&
                     !(((prep_i.op == exu_pkg::OP_ADD) ||
                        (prep_i.op == exu_pkg::OP_SUB)) && ov_sum);
        case (prep_i.op)
            exu_pkg::OP_OR, exu_pkg::OP_AND,
            exu_pkg::OP_NOR, exu_pkg::OP_XOR:  res_d.wdata = logic_res;
            exu_pkg::OP_SLL, exu_pkg::OP_SRL,
            exu_pkg::OP_SRA:                   res_d.wdata = shift_res;
            exu_pkg::OP_ADD, exu_pkg::OP_ADDU,
            exu_pkg::OP_SUB, exu_pkg::OP_SUBU,
            exu_pkg::OP_SLT, exu_pkg::OP_SLTU,
            exu_pkg::OP_CLZ, exu_pkg::OP_CLO:  res_d.wdata = arith_res;
            exu_pkg::OP_MUL:                   res_d.wdata = prod[`EXU_XLEN-1:0];
            exu_pkg::OP_MFHI, exu_pkg::OP_MFLO: res_d.wdata = move_res;
            default:                           res_d.wdata = '0;
        endcase
    end

    always_comb begin
        hilo_d = '0;
        case (prep_i.op)
            exu_pkg::OP_MULT, exu_pkg::OP_MULTU: begin
                hilo_d.we = 1'b1;
                hilo_d.hi = prod[2*`EXU_XLEN-1:`EXU_XLEN];
                hilo_d.lo = prod[`EXU_XLEN-1:0];
            end
            exu_pkg::OP_MTHI: begin
                hilo_d.we = 1'b1;
                hilo_d.hi = prep_i.reg1;
                hilo_d.lo = lo_i;               // lo unchanged
            end
            exu_pkg::OP_MTLO: begin
                hilo_d.we = 1'b1;
                hilo_d.hi = hi_i;
                hilo_d.lo = prep_i.reg1;
            end
            default: ;
        endcase
        hilo_d.we = hilo_d.we && prep_valid_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            res_q   <= '0;
            hilo_q  <= '0;
        end else begin
            valid_q <= prep_valid_i;
            res_q   <= res_d;
            hilo_q  <= hilo_d;
        end
    end

    assign ex_valid_o = valid_q;
    assign ex_res_o   = res_q;
    assign ex_hilo_o  = hilo_q;

endmodule

/* design/exu_hilo_regs.sv */
// ------------------------------------------------
// hi/lo register pair
// with a forwarded view of the pending write
// ------------------------------------------------

`timescale 1ns/1ps

module exu_hilo_regs (
    input  logic                clk,
    input  logic                rst_n_i,
    input  exu_pkg::hilo_wr_t   wr_i,
    output exu_pkg::word_t      hi_fwd_o,
    output exu_pkg::word_t      lo_fwd_o,
    output exu_pkg::word_t      hi_o,
    output exu_pkg::word_t      lo_o
);

    exu_pkg::word_t hi_q;
    exu_pkg::word_t lo_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (wr_i.we) begin
            hi_q <= wr_i.hi;
            lo_q <= wr_i.lo;
        end
    end

    // in-flight write is newer than the stored pair
    assign hi_fwd_o = wr_i.we ? wr_i.hi : hi_q;
    assign lo_fwd_o = wr_i.we ? wr_i.lo : lo_q;

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

/* design/exu_operand_stage.sv */
// ------------------------------------------------
// execute unit operand stage
// registers the request with the adder operand
// and multiplier magnitudes already prepared
// ------------------------------------------------

`timescale 1ns/1ps

`include "exu_defs.svh"

module exu_operand_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  exu_pkg::exu_req_t   req_i,
    output logic                prep_valid_o,
    output exu_pkg::exu_prep_t  prep_o
);

    exu_pkg::exu_prep_t prep_d;
    exu_pkg::exu_prep_t prep_q;
    logic               prep_valid_q;
    logic               is_sub;
    logic               is_smul;

    function automatic exu_pkg::word_t magnitude(input exu_pkg::word_t v);
        return v[`EXU_XLEN-1] ? -v : v;
    endfunction

    // slt reuses the subtract path for its signed compare
    assign is_sub = (req_i.op == exu_pkg::OP_SUB)  ||
                    (req_i.op == exu_pkg::OP_SUBU) ||
                    (req_i.op == exu_pkg::OP_SLT);

    assign is_smul = (req_i.op == exu_pkg::OP_MUL) ||
                     (req_i.op == exu_pkg::OP_MULT);

    always_comb begin
        prep_d.op       = req_i.op;
        prep_d.reg1     = req_i.reg1;
        prep_d.reg2     = req_i.reg2;
        prep_d.reg2_mux = is_sub ? -req_i.reg2 : req_i.reg2;
        prep_d.mul_a    = is_smul ? magnitude(req_i.reg1) : req_i.reg1;
        prep_d.mul_b    = is_smul ? magnitude(req_i.reg2) : req_i.reg2;
        prep_d.mul_neg  = is_smul && (req_i.reg1[`EXU_XLEN-1] ^ req_i.reg2[`EXU_XLEN-1]);
        prep_d.wd       = req_i.wd;
        prep_d.wreg     = req_valid_i && req_i.wreg;   // bubble drops the write
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prep_valid_q <= 1'b0;
            prep_q       <= '0;
        end else begin
            prep_valid_q <= req_valid_i;
            prep_q       <= prep_d;
        end
    end

    assign prep_valid_o = prep_valid_q;
    assign prep_o       = prep_q;

endmodule

/* design/exu_pkg.sv */
// ------------------------------------------------
// execute unit shared types
// opcodes, word types and the per-stage structs
// ------------------------------------------------

`include "exu_defs.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]       word_t;
    typedef logic [2*`EXU_XLEN-1:0]     dword_t;    // hi in the upper half
    typedef logic [`EXU_REG_ADDR_W-1:0] reg_addr_t;

    // OP_NOP first so a cleared struct reads as a nop
    typedef enum logic [4:0] {
        OP_NOP,
        OP_OR, OP_AND, OP_NOR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTU,
        OP_CLZ, OP_CLO,
        OP_MUL, OP_MULT, OP_MULTU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO
    } alu_op_e;

    typedef struct packed {
        alu_op_e    op;
        word_t      reg1;
        word_t      reg2;       // immediate already placed here by decode
        reg_addr_t  wd;
        logic       wreg;
    } exu_req_t;

    typedef struct packed {
        alu_op_e    op;
        word_t      reg1;
        word_t      reg2;
        word_t      reg2_mux;   // reg2 or its two's complement
        word_t      mul_a;      // multiplier magnitudes
        word_t      mul_b;
        logic       mul_neg;    // signs differed on a signed multiply
        reg_addr_t  wd;
        logic       wreg;
    } exu_prep_t;

    typedef struct packed {
        logic   we;
        word_t  hi;
        word_t  lo;
    } hilo_wr_t;

    typedef struct packed {
        logic       wreg;
        reg_addr_t  wd;
        word_t      wdata;
    } exu_result_t;

endpackage

/* design/exu_top.sv */
// ------------------------------------------------
// three-stage integer execute unit
// operand, execute and writeback stages in a row
// ------------------------------------------------

`timescale 1ns/1ps

module exu_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    input  exu_pkg::exu_req_t       req_i,
    output logic                    res_valid_o,
    output exu_pkg::exu_result_t    res_o,
    output exu_pkg::word_t          hi_o,       // committed hi/lo
    output exu_pkg::word_t          lo_o
);

    logic                   prep_valid;
    exu_pkg::exu_prep_t     prep;
    logic                   ex_valid;
    exu_pkg::exu_result_t   ex_res;
    exu_pkg::hilo_wr_t      ex_hilo;
    exu_pkg::word_t         hilo_fwd_hi;
    exu_pkg::word_t         hilo_fwd_lo;

    exu_operand_stage u_operand (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .prep_valid_o (prep_valid),
        .prep_o       (prep)
    );

    exu_execute_stage u_execute (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .prep_valid_i (prep_valid),
        .prep_i       (prep),
        .hi_i         (hilo_fwd_hi),
        .lo_i         (hilo_fwd_lo),
        .ex_valid_o   (ex_valid),
        .ex_res_o     (ex_res),
        .ex_hilo_o    (ex_hilo)
    );

    exu_writeback_stage u_writeback (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ex_valid_i   (ex_valid),
        .ex_res_i     (ex_res),
        .ex_hilo_i    (ex_hilo),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o),
        .hi_fwd_o     (hilo_fwd_hi),
        .lo_fwd_o     (hilo_fwd_lo),
        .hi_o         (hi_o),
        .lo_o         (lo_o)
    );

endmodule

/* design/exu_writeback_stage.sv */
// ------------------------------------------------
// execute unit writeback stage
// registers the gpr result and commits hi/lo
// ------------------------------------------------

`timescale 1ns/1ps

module exu_writeback_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    ex_valid_i,
    input  exu_pkg::exu_result_t    ex_res_i,
    input  exu_pkg::hilo_wr_t       ex_hilo_i,
    output logic                    res_valid_o,
    output exu_pkg::exu_result_t    res_o,
    output exu_pkg::word_t          hi_fwd_o,
    output exu_pkg::word_t          lo_fwd_o,
    output exu_pkg::word_t          hi_o,
    output exu_pkg::word_t          lo_o
);

    exu_pkg::hilo_wr_t      commit;
    exu_pkg::exu_result_t   res_q;
    logic                   res_valid_q;

    always_comb begin
        commit    = ex_hilo_i;
        commit.we = ex_valid_i && ex_hilo_i.we;     // only valid items commit
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
            res_q       <= '0;
        end else begin
            res_valid_q <= ex_valid_i;
            res_q       <= ex_res_i;
            res_q.wreg  <= ex_valid_i && ex_res_i.wreg;
        end
    end

    exu_hilo_regs u_hilo (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wr_i     (commit),
        .hi_fwd_o (hi_fwd_o),
        .lo_fwd_o (lo_fwd_o),
        .hi_o     (hi_o),
        .lo_o     (lo_o)
    );

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

/* testbench/tb_exu.sv */
// ------------------------------------------------
// testbench for the three-stage execute unit
// random and directed requests against a model
// ------------------------------------------------

`timescale 1ns/1ps

module tb_exu;

    typedef struct packed {
        exu_pkg::exu_result_t res;
        exu_pkg::dword_t      hilo;     // hi/lo after this item
    } model_out_t;

    logic                   clk;
    logic                   rst_n_i;
    logic                   req_valid_i;
    exu_pkg::exu_req_t      req_i;
    logic                   res_valid_o;
    exu_pkg::exu_result_t   res_o;
    exu_pkg::word_t         hi_o;
    exu_pkg::word_t         lo_o;

    int                     cyc = 0;
    logic [31:0]            rng_state = 32'hc609f13e;
    exu_pkg::dword_t        model_hilo = '0;   // issue-order hi/lo
    exu_pkg::dword_t        committed = '0;    // what hi_o/lo_o should show
    model_out_t             exp_q[$];
    int                     due_q[$];          // cycle each result is due

    exu_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .hi_o        (hi_o),
        .lo_o        (lo_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic exu_pkg::alu_op_e pick_op(input int first, input int count);
        logic [31:0] r;
        r = next_rand();
        return exu_pkg::alu_op_e'(5'(first + int'(r % count)));
    endfunction

    function automatic exu_pkg::exu_req_t rand_req(input int first, input int count);
        exu_pkg::exu_req_t req;
        logic [31:0]       r;
        r         = next_rand();
        req.op    = pick_op(first, count);
        req.reg1  = next_rand();
        req.reg2  = next_rand();
        req.wd    = r[4:0];
        req.wreg  = r[5];
        return req;
    endfunction

    // expected result and hi/lo, taken in issue order
    function automatic model_out_t exu_model(input exu_pkg::exu_req_t req,
                                             input exu_pkg::dword_t hilo);
        model_out_t     m;
        exu_pkg::word_t a;
        exu_pkg::word_t b;
        logic [4:0]     sh;
        longint         s;
        logic           ov;
        int             n;
        a           = req.reg1;
        b           = req.reg2;
        sh          = a[4:0];
        s           = longint'($signed(a)) * longint'($signed(b));  // signed product
        m.hilo      = hilo;
        m.res.wd    = req.wd;
        m.res.wreg  = req.wreg;
        m.res.wdata = '0;
        ov          = 1'b0;
        n           = 0;
        case (req.op)
            exu_pkg::OP_OR:    m.res.wdata = a | b;
            exu_pkg::OP_AND:   m.res.wdata = a & b;
            exu_pkg::OP_NOR:   m.res.wdata = ~(a | b);
            exu_pkg::OP_XOR:   m.res.wdata = a ^ b;
            exu_pkg::OP_SLL:   m.res.wdata = b << sh;
            exu_pkg::OP_SRL:   m.res.wdata = b >> sh;
            exu_pkg::OP_SRA:   m.res.wdata = (b >> sh) | (b[31] ? ~(32'hffffffff >> sh) : 32'h0);
            exu_pkg::OP_MUL:   m.res.wdata = s[31:0];
            exu_pkg::OP_MULT:  m.hilo = s;
            exu_pkg::OP_MULTU: m.hilo = {32'h0, a} * {32'h0, b};
            exu_pkg::OP_SLT:   m.res.wdata = {31'b0, $signed(a) < $signed(b)};
            exu_pkg::OP_SLTU:  m.res.wdata = {31'b0, a < b};
            exu_pkg::OP_MFHI:  m.res.wdata = hilo[63:32];
            exu_pkg::OP_MFLO:  m.res.wdata = hilo[31:0];
            exu_pkg::OP_MTHI:  m.hilo = {a, hilo[31:0]};
            exu_pkg::OP_MTLO:  m.hilo = {hilo[63:32], a};
            exu_pkg::OP_ADD, exu_pkg::OP_ADDU,
            exu_pkg::OP_SUB, exu_pkg::OP_SUBU: begin
                if (req.op == exu_pkg::OP_ADD || req.op == exu_pkg::OP_ADDU)
                    s = longint'($signed(a)) + longint'($signed(b));
                else
                    s = longint'($signed(a)) - longint'($signed(b));
                m.res.wdata = s[31:0];
                ov = (s[32] != s[31]);     // exact sum does not fit 32 bits
            end
            exu_pkg::OP_CLZ, exu_pkg::OP_CLO: begin
                for (int i = 31; i >= 0; i--) begin
                    if (a[i] != (req.op == exu_pkg::OP_CLO)) break;
                    n++;
                end
                m.res.wdata = n;
            end
            default: ;
        endcase
        if ((req.op == exu_pkg::OP_ADD || req.op == exu_pkg::OP_SUB) && ov)
            m.res.wreg = 1'b0;
        return m;
    endfunction

    task automatic end_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input exu_pkg::exu_result_t exp,
                                input exu_pkg::exu_result_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected wreg=%h wd=%h wdata=%h got wreg=%h wd=%h wdata=%h",
                     name, exp.wreg, exp.wd, exp.wdata, act.wreg, act.wd, act.wdata);
            end_with_failure();
        end
    endtask

    task automatic check_hilo(input string name, input exu_pkg::dword_t exp,
                              input exu_pkg::dword_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic send(input exu_pkg::exu_req_t req);
        model_out_t m;
        m          = exu_model(req, model_hilo);
        model_hilo = m.hilo;
        exp_q.push_back(m);
        due_q.push_back(cyc + 3);   // sampled next edge, visible two edges on
        req_valid_i = 1'b1;
        req_i       = req;
        @(posedge clk);
        #1;
    endtask

    task automatic issue(input exu_pkg::alu_op_e op, input exu_pkg::word_t a,
                         input exu_pkg::word_t b);
        exu_pkg::exu_req_t req;
        req      = rand_req(0, 23);
        req.op   = op;
        req.reg1 = a;
        req.reg2 = b;
        req.wreg = 1'b1;
        send(req);
    endtask

    // bubbles carry junk so a dropped write would show
    task automatic idle(input int n);
        repeat (n) begin
            req_valid_i = 1'b0;
            req_i       = rand_req(0, 23);
            @(posedge clk);
            #1;
        end
    endtask

    // compare each result at the falling edge, away from the drive time
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n_i) begin
                if (res_valid_o) begin
                    if (exp_q.size() == 0) begin
                        $display("result came out with no request pending");
                        end_with_failure();
                    end
                    if (due_q[0] != cyc) begin
                        $display("result came at cycle %0d but was due at cycle %0d",
                                 cyc, due_q[0]);
                        end_with_failure();
                    end
                    check_result("res_o", exp_q[0].res, res_o);
                    committed = exp_q[0].hilo;
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
                    $display("no result came for the request due at cycle %0d", due_q[0]);
                    end_with_failure();
                end
                check_hilo("hi_o:lo_o", committed, {hi_o, lo_o});
            end
        end
    end

    initial begin
        exu_pkg::word_t a;
        exu_pkg::word_t b;
        int             guard;
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        idle(4);                    // quiet outputs after reset

        for (int i = 0; i < 40; i++) send(rand_req(1, 7));   // logic and shift
        issue(exu_pkg::OP_SRA, 32'd0, 32'h8000_0010);
        issue(exu_pkg::OP_SRA, 32'd31, 32'h8000_0000);
        issue(exu_pkg::OP_SRL, 32'd31, 32'hffff_ffff);
        issue(exu_pkg::OP_SLL, 32'd31, 32'h0000_0001);
        issue(exu_pkg::OP_SLL, 32'd0, 32'h1234_5678);

        issue(exu_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        issue(exu_pkg::OP_ADDU, 32'h7fff_ffff, 32'h0000_0001);
        issue(exu_pkg::OP_ADD, 32'h8000_0000, 32'h8000_0000);
        issue(exu_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001);
        issue(exu_pkg::OP_SUBU, 32'h8000_0000, 32'h0000_0001);
        issue(exu_pkg::OP_SUB, 32'h7fff_ffff, 32'hffff_ffff);
        issue(exu_pkg::OP_SUB, 32'h0000_0000, 32'h8000_0000);
        issue(exu_pkg::OP_SUB, 32'hffff_ffff, 32'h8000_0000);
        issue(exu_pkg::OP_SLT, 32'hffff_fffe, 32'h0000_0001);
        issue(exu_pkg::OP_SLTU, 32'hffff_fffe, 32'h0000_0001);
        issue(exu_pkg::OP_CLZ, 32'h0, 32'h0);
        issue(exu_pkg::OP_CLO, 32'hffff_ffff, 32'h0);
        issue(exu_pkg::OP_CLZ, 32'h1, 32'h0);
        for (int i = 0; i < 40; i++) begin
            a = next_rand();
            b = next_rand();
            issue(pick_op(8, 8), a >> b[4:0], b);   // shorter operands vary the counts
        end

        for (int i = 0; i < 24; i++) begin
            a = next_rand();
            b = next_rand();
            b[31] = a[31] ^ i[0];
            issue(pick_op(16, 3), a, b);
        end

        // hi/lo reads right behind and two edges behind a writer
        issue(exu_pkg::OP_MTHI, 32'h1234_5678, 32'h0);
        issue(exu_pkg::OP_MFHI, 32'h0, 32'h0);
        issue(exu_pkg::OP_MFLO, 32'h0, 32'h0);
        issue(exu_pkg::OP_MTLO, 32'h9abc_def0, 32'h0);
        issue(exu_pkg::OP_MFLO, 32'h0, 32'h0);
        issue(exu_pkg::OP_MFHI, 32'h0, 32'h0);
        issue(exu_pkg::OP_MULT, 32'hffff_fff9, 32'h0000_1000);
        issue(exu_pkg::OP_MFHI, 32'h0, 32'h0);
        issue(exu_pkg::OP_MFLO, 32'h0, 32'h0);
        issue(exu_pkg::OP_MTHI, 32'hcafe_0001, 32'h0);
        idle(1);
        issue(exu_pkg::OP_MFHI, 32'h0, 32'h0);
        issue(exu_pkg::OP_MFLO, 32'h0, 32'h0);
        issue(exu_pkg::OP_MULTU, 32'hffff_ffff, 32'h0000_0003);
        idle(1);
        issue(exu_pkg::OP_MFLO, 32'h0, 32'h0);
        issue(exu_pkg::OP_MFHI, 32'h0, 32'h0);

        for (int i = 0; i < 150; i++) begin
            a = next_rand();
            if (a[1:0] == 2'b00) idle(1 + int'(a[3:2]));
            send(rand_req(0, 23));
        end
        idle(1);

        guard = 0;
        while (exp_q.size() != 0 && guard < 20) begin
            @(posedge clk);
            guard++;
        end
        if (exp_q.size() != 0) begin
            $display("results still pending after the drain timeout");
            end_with_failure();
        end else begin
            idle(4);
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+design
design/exu_pkg.sv
design/exu_hilo_regs.sv
design/exu_operand_stage.sv
design/exu_execute_stage.sv
design/exu_writeback_stage.sv
design/exu_top.sv
testbench/tb_exu.sv
